// File: src/rv_mem_pkg.sv
`default_nettype none

package rv_mem_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [31:0]       addr_t;
  typedef logic [XLEN/8-1:0] strb_t;
  typedef logic [4:0]        reg_idx_t;

  // Writeback value source
  typedef enum logic [2:0] {
    RES_ALU  = 3'd0,
    RES_LOAD = 3'd1,
    RES_PC4  = 3'd2,
    RES_JB   = 3'd3,
    RES_CSR  = 3'd4,
    RES_M    = 3'd5
  } res_src_e;

  // Load/store funct3 encodings
  typedef enum logic [2:0] {
    LS_B  = 3'b000,
    LS_H  = 3'b001,
    LS_W  = 3'b010,
    LS_BU = 3'b100,
    LS_HU = 3'b101
  } ls_width_e;

  // addi x0, x0, 0
  localparam logic [31:0] I_NOP = 32'h0000_0013;

  typedef struct packed {
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    res_src_e  res_src;
    logic [31:0] instr;
    reg_idx_t  rd;
    ls_width_e funct3;
    xlen_t     alu_result;
    xlen_t     rs2_data;
    xlen_t     pc_plus4;
    xlen_t     jb_target;
    xlen_t     csr_rdata;
    xlen_t     m_result;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    res_src_e  res_src;
    logic [31:0] instr;
    reg_idx_t  rd;
    ls_width_e funct3;
    logic [1:0] addr_lo;
    xlen_t     alu_result;
    xlen_t     pc_plus4;
    xlen_t     jb_target;
    xlen_t     csr_rdata;
    xlen_t     m_result;
  } mem_wb_t;

  typedef struct packed {
    logic  ren;
    logic  we;
    addr_t addr;
    xlen_t wdata;
    strb_t wstrb;
  } dmem_req_t;

endpackage

`default_nettype wire

// File: src/rv_st_fmt.sv
`timescale 1ns/1ps
`default_nettype none

module rv_st_fmt (
  input  rv_mem_pkg::xlen_t     data_in,
  input  logic [1:0]            addr_lo,
  input  rv_mem_pkg::ls_width_e funct3,
  input  logic                  mem_write,
  output rv_mem_pkg::xlen_t     data_out,
  output rv_mem_pkg::strb_t     wstrb
);

  rv_mem_pkg::strb_t lane_strb;

  // Replicate the store operand so every lane carries it,
  // the strobes then pick the lanes actually written
  always_comb begin
    case (funct3)
      rv_mem_pkg::LS_B, rv_mem_pkg::LS_BU: begin
        data_out  = {4{data_in[7:0]}};
        lane_strb = 4'b0001 << addr_lo;
      end
      rv_mem_pkg::LS_H, rv_mem_pkg::LS_HU: begin
        data_out  = {2{data_in[15:0]}};
        lane_strb = addr_lo[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        data_out  = data_in;
        lane_strb = 4'b1111;
      end
    endcase
  end

  // No lanes enabled unless this is a store
  assign wstrb = mem_write ? lane_strb : '0;

endmodule

`default_nettype wire

// File: src/rv_ld_fmt.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ld_fmt (
  input  rv_mem_pkg::xlen_t     data_in,
  input  logic [1:0]            addr_lo,
  input  rv_mem_pkg::ls_width_e funct3,
  output rv_mem_pkg::xlen_t     data_out
);

  rv_mem_pkg::xlen_t shifted;
  logic [7:0]        ld_byte;
  logic [15:0]       ld_half;

  // Bring the addressed lane down to bit 0
  assign shifted = data_in >> {addr_lo, 3'b000};
  assign ld_byte = shifted[7:0];
  assign ld_half = shifted[15:0];

  always_comb begin
    case (funct3)
      rv_mem_pkg::LS_B: begin
        data_out = {{24{ld_byte[7]}}, ld_byte};
      end
      rv_mem_pkg::LS_H: begin
        data_out = {{16{ld_half[15]}}, ld_half};
      end
      rv_mem_pkg::LS_BU: begin
        data_out = {24'b0, ld_byte};
      end
      rv_mem_pkg::LS_HU: begin
        data_out = {16'b0, ld_half};
      end
      default: begin
        // Word loads are aligned, pass the raw word
        data_out = data_in;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/rv_dmem.sv
`timescale 1ns/1ps
`default_nettype none

module rv_dmem #(
  parameter int DEPTH_WORDS = 1024
) (
  input  logic                  clk,
  input  rv_mem_pkg::dmem_req_t req,
  output rv_mem_pkg::xlen_t     rdata
);

  localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
  localparam int LANES = $bits(rv_mem_pkg::strb_t);

  rv_mem_pkg::xlen_t mem [DEPTH_WORDS];
  logic [IDX_W-1:0]  idx;

  // Word index sits right above the byte offset
  assign idx = req.addr[IDX_W+1:2];

  // Byte-lane writes
  always_ff @(posedge clk) begin
    if (req.we) begin
      for (int i = 0; i < LANES; i++) begin
        if (req.wstrb[i]) begin
          mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  // BRAM-style read, the word is held between reads
  always_ff @(posedge clk) begin
    if (req.ren) begin
      rdata <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// File: src/rv_dmem_arb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_dmem_arb (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_mem_pkg::dmem_req_t pipe_req,
  input  logic                  stall,
  input  logic                  host_req,
  input  logic                  host_we,
  input  rv_mem_pkg::addr_t     host_addr,
  input  rv_mem_pkg::xlen_t     host_wdata,
  input  rv_mem_pkg::strb_t     host_wstrb,
  output rv_mem_pkg::dmem_req_t ram_req,
  output logic                  host_gnt
);

  rv_mem_pkg::dmem_req_t host_dreq;
  logic                  pipe_active;
  logic                  arb_ready;

  // Keeps the host off the RAM until reset has been released
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arb_ready <= 1'b0;
    end else begin
      arb_ready <= 1'b1;
    end
  end

  assign pipe_active = pipe_req.ren | pipe_req.we;

  // Host request as a RAM access
  always_comb begin
    host_dreq.ren   = ~host_we;
    host_dreq.we    = host_we;
    host_dreq.addr  = host_addr;
    host_dreq.wdata = host_wdata;
    host_dreq.wstrb = host_we ? host_wstrb : '0;
  end

  // Pipeline has fixed priority
  // Host only gets idle, unstalled cycles
  assign host_gnt = rst_n & arb_ready & host_req & ~pipe_active & ~stall;

  always_comb begin
    if (pipe_active) begin
      ram_req = pipe_req;
    end else if (host_gnt) begin
      ram_req = host_dreq;
    end else begin
      ram_req = '0;
    end
  end

endmodule

`default_nettype wire

// File: src/rv_stage_mem.sv
`timescale 1ns/1ps
`default_nettype none

module rv_stage_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  mem_wb_stall,
  input  rv_mem_pkg::ex_mem_t   ex_mem,
  input  rv_mem_pkg::xlen_t     ram_rdata,
  output rv_mem_pkg::dmem_req_t pipe_req,
  output rv_mem_pkg::xlen_t     result_mem,
  output rv_mem_pkg::mem_wb_t   mem_wb,
  output rv_mem_pkg::xlen_t     load_data_wb
);

  rv_mem_pkg::xlen_t   st_wdata;
  rv_mem_pkg::strb_t   st_wstrb;
  rv_mem_pkg::mem_wb_t mem_wb_next;

  // Store data goes out on the byte lanes picked by the address
  rv_st_fmt u_st_fmt (
    .data_in  (ex_mem.rs2_data),
    .addr_lo  (ex_mem.alu_result[1:0]),
    .funct3   (ex_mem.funct3),
    .mem_write(ex_mem.mem_write),
    .data_out (st_wdata),
    .wstrb    (st_wstrb)
  );

  // RAM request from the EX/MEM fields
  always_comb begin
    pipe_req.ren   = ex_mem.mem_read;
    pipe_req.we    = ex_mem.mem_write;
    pipe_req.addr  = ex_mem.alu_result;
    pipe_req.wdata = st_wdata;
    pipe_req.wstrb = st_wstrb;
  end

  // Forwarding result, loads are not ready until WB
  assign result_mem = (ex_mem.res_src == rv_mem_pkg::RES_M) ? ex_mem.m_result
                                                             : ex_mem.alu_result;

  // Next MEM/WB contents
  always_comb begin
    mem_wb_next.reg_write  = ex_mem.reg_write;
    mem_wb_next.res_src    = ex_mem.res_src;
    mem_wb_next.instr      = ex_mem.instr;
    mem_wb_next.rd         = ex_mem.rd;
    mem_wb_next.funct3     = ex_mem.funct3;
    mem_wb_next.addr_lo    = ex_mem.alu_result[1:0];
    mem_wb_next.alu_result = ex_mem.alu_result;
    mem_wb_next.pc_plus4   = ex_mem.pc_plus4;
    mem_wb_next.jb_target  = ex_mem.jb_target;
    mem_wb_next.csr_rdata  = ex_mem.csr_rdata;
    mem_wb_next.m_result   = ex_mem.m_result;
  end

  // MEM/WB register, bubbles in as a NOP
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb       <= '0;
      mem_wb.instr <= rv_mem_pkg::I_NOP;
    end else if (!mem_wb_stall) begin
      mem_wb <= mem_wb_next;
    end
  end

  // The RAM word lands one cycle after the read, together with mem_wb,
  // so the lane select uses the registered funct3 and address bits
  rv_ld_fmt u_ld_fmt (
    .data_in (ram_rdata),
    .addr_lo (mem_wb.addr_lo),
    .funct3  (mem_wb.funct3),
    .data_out(load_data_wb)
  );

endmodule

`default_nettype wire

// File: src/rv_mem_sub.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mem_sub #(
  parameter int DEPTH_WORDS = 1024
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  mem_wb_stall,
  input  rv_mem_pkg::ex_mem_t   ex_mem,
  input  logic                  host_req,
  input  logic                  host_we,
  input  rv_mem_pkg::addr_t     host_addr,
  input  rv_mem_pkg::xlen_t     host_wdata,
  input  rv_mem_pkg::strb_t     host_wstrb,
  output logic                  host_gnt,
  output rv_mem_pkg::xlen_t     host_rdata,
  output rv_mem_pkg::xlen_t     result_mem,
  output rv_mem_pkg::mem_wb_t   mem_wb,
  output rv_mem_pkg::xlen_t     load_data_wb
);

  rv_mem_pkg::dmem_req_t pipe_req;
  rv_mem_pkg::dmem_req_t ram_req;

  // host_rdata is the raw RAM word, also feeding the load formatter
  rv_stage_mem u_stage_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_wb_stall(mem_wb_stall),
    .ex_mem      (ex_mem),
    .ram_rdata   (host_rdata),
    .pipe_req    (pipe_req),
    .result_mem  (result_mem),
    .mem_wb      (mem_wb),
    .load_data_wb(load_data_wb)
  );

  rv_dmem_arb u_dmem_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .pipe_req  (pipe_req),
    .stall     (mem_wb_stall),
    .host_req  (host_req),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .host_wstrb(host_wstrb),
    .ram_req   (ram_req),
    .host_gnt  (host_gnt)
  );

  rv_dmem #(
    .DEPTH_WORDS(DEPTH_WORDS)
  ) u_dmem (
    .clk  (clk),
    .req  (ram_req),
    .rdata(host_rdata)
  );

endmodule

`default_nettype wire

// File: bench/rv_mem_sub_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mem_sub_asserts (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  mem_wb_stall,
  input logic                  host_req,
  input logic                  host_gnt,
  input rv_mem_pkg::dmem_req_t pipe_req,
  input rv_mem_pkg::mem_wb_t   mem_wb
);

  int fail_cnt = 0;

  // Pipeline owns the RAM whenever it accesses it or is stalled
  a_gnt_idle: assert property (@(posedge clk) disable iff (!rst_n)
    host_gnt |-> !pipe_req.ren && !pipe_req.we && !mem_wb_stall)
    else begin
      $error("host granted during pipeline access or stall");
      fail_cnt++;
    end

  a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n) host_gnt |-> host_req)
    else begin
      $error("host granted without a request");
      fail_cnt++;
    end

  a_rst_gnt: assert property (@(posedge clk) !rst_n |-> !host_gnt)
    else begin
      $error("host granted during reset");
      fail_cnt++;
    end

  // MEM/WB holds a NOP bubble when reset is released
  a_rst_wb: assert property (@(posedge clk) $rose(rst_n) |->
    !mem_wb.reg_write && mem_wb.instr == rv_mem_pkg::I_NOP && mem_wb.rd == '0 &&
    mem_wb.alu_result == '0)
    else begin
      $error("MEM/WB reset value wrong");
      fail_cnt++;
    end

endmodule

bind rv_mem_sub rv_mem_sub_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .mem_wb_stall(mem_wb_stall),
  .host_req    (host_req),
  .host_gnt    (host_gnt),
  .pipe_req    (pipe_req),
  .mem_wb      (mem_wb)
);

`default_nettype wire

// File: bench/rv_mem_sub_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mem_sub_tb;

  logic clk = 1'b0;
  logic rst_n, mem_wb_stall, host_req, host_we, host_gnt;
  rv_mem_pkg::ex_mem_t ex_mem;
  rv_mem_pkg::mem_wb_t mem_wb;
  rv_mem_pkg::addr_t   host_addr;
  rv_mem_pkg::xlen_t   host_wdata, host_rdata, result_mem, load_data_wb;
  rv_mem_pkg::strb_t   host_wstrb;
  // Expected load result, issue stage and WB stage
  logic ld_d_valid = 1'b0, ld_q_valid = 1'b0, hrd_valid = 1'b0;
  rv_mem_pkg::xlen_t ld_d_data, ld_q_data, hrd_data;
  logic [7:0]  model [0:255];
  logic [31:0] lfsr = 32'd84276;

  rv_mem_sub #(.DEPTH_WORDS(64)) UUT (.*);

  initial begin
    forever #10 clk = ~clk;
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Byte, halfword or word from the model, extended per funct3
  function automatic rv_mem_pkg::xlen_t expect_load(input int a, input rv_mem_pkg::ls_width_e w);
    case (w)
      rv_mem_pkg::LS_B:  return {{24{model[a][7]}}, model[a]};
      rv_mem_pkg::LS_BU: return {24'b0, model[a]};
      rv_mem_pkg::LS_H:  return {{16{model[a+1][7]}}, model[a+1], model[a]};
      rv_mem_pkg::LS_HU: return {16'b0, model[a+1], model[a]};
      default:           return {model[a+3], model[a+2], model[a+1], model[a]};
    endcase
  endfunction

  task automatic random_idle(output rv_mem_pkg::ex_mem_t e);
    logic [31:0] r;
    e = '0;
    take_bits(4, r);
    e.reg_write = r[3];
    e.res_src   = rv_mem_pkg::res_src_e'(r[2:0] % 3'd6);
    take_bits(32, r);
    e.instr = r;
    take_bits(5, r);
    e.rd = r[4:0];
    take_bits(32, r);
    e.alu_result = r;
    take_bits(32, r);
    e.pc_plus4 = r;
    take_bits(32, r);
    e.jb_target = r;
    take_bits(32, r);
    e.csr_rdata = r;
    take_bits(32, r);
    e.m_result = r;
    e.funct3 = rv_mem_pkg::LS_W;
  endtask

  // One pipeline cycle, called right after a rising edge
  task automatic pipe_cycle(input rv_mem_pkg::ex_mem_t e, input logic stall_v);
    ex_mem       <= e;
    mem_wb_stall <= stall_v;
    ld_d_valid   <= e.mem_read;
    ld_d_data    <= expect_load(int'(e.alu_result[7:0]), e.funct3);
    @(posedge clk);
  endtask

  task automatic mem_op(input logic is_store, input logic [7:0] a, input logic [2:0] wsel,
                        output rv_mem_pkg::ex_mem_t e);
    logic [31:0] d;
    random_idle(e);
    take_bits(32, d);
    if (is_store) begin
      e.funct3 = (wsel % 3'd3 == 0) ? rv_mem_pkg::LS_B :
                 (wsel % 3'd3 == 1) ? rv_mem_pkg::LS_H : rv_mem_pkg::LS_W;
    end else begin
      case (wsel % 3'd5)
        0: e.funct3 = rv_mem_pkg::LS_B;
        1: e.funct3 = rv_mem_pkg::LS_H;
        2: e.funct3 = rv_mem_pkg::LS_W;
        3: e.funct3 = rv_mem_pkg::LS_BU;
        default: e.funct3 = rv_mem_pkg::LS_HU;
      endcase
    end
    // Natural alignment for the access width
    if (e.funct3 == rv_mem_pkg::LS_W) a[1:0] = 2'b00;
    else if (e.funct3 != rv_mem_pkg::LS_B && e.funct3 != rv_mem_pkg::LS_BU) a[0] = 1'b0;
    e.alu_result = {24'b0, a};
    e.rs2_data   = d;
    e.mem_write  = is_store;
    e.mem_read   = !is_store;
    e.res_src    = is_store ? rv_mem_pkg::RES_ALU : rv_mem_pkg::RES_LOAD;
    if (is_store) begin
      model[a] = d[7:0];
      if (e.funct3 != rv_mem_pkg::LS_B) begin
        model[a+1] = d[15:8];
      end
      if (e.funct3 == rv_mem_pkg::LS_W) begin
        model[a+2] = d[23:16];
        model[a+3] = d[31:24];
      end
    end
  endtask

  task automatic host_access(input logic we, input logic [7:0] a, input rv_mem_pkg::strb_t s,
                             input logic [1:0] busy);
    rv_mem_pkg::ex_mem_t e;
    rv_mem_pkg::ex_mem_t first;
    logic [31:0] d;
    int waited;
    random_idle(e);
    take_bits(32, d);
    waited = 0;
    first = e;
    // First request cycle may meet a stall or a pipeline load
    if (busy == 2'd2) begin
      mem_op(1'b0, ~a, d[2:0], first);
    end
    ex_mem <= first;
    mem_wb_stall <= (busy == 2'd1);
    ld_d_valid <= first.mem_read;
    ld_d_data <= expect_load(int'(first.alu_result[7:0]), first.funct3);
    host_req <= 1'b1;
    host_we <= we;
    host_addr <= {24'b0, a[7:2], 2'b00};
    host_wdata <= d;
    host_wstrb <= s;
    @(posedge clk);
    ex_mem <= e;
    mem_wb_stall <= 1'b0;
    ld_d_valid <= 1'b0;
    while (!host_gnt) begin
      waited++;
      if (waited > 20) begin
        stop_on_error("Host request was never granted while the pipeline was idle");
      end
      @(posedge clk);
    end
    host_req <= 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (we && s[i]) model[{a[7:2], 2'b00} + i] = d[8*i +: 8];
    end
    hrd_valid <= !we;
    hrd_data  <= expect_load(int'({a[7:2], 2'b00}), rv_mem_pkg::LS_W);
    @(posedge clk);
    hrd_valid <= 1'b0;
  endtask

  // WB-stage copy of the expected load, held under a stall
  always @(posedge clk) begin
    if (!rst_n) begin
      ld_q_valid <= 1'b0;
    end else if (!mem_wb_stall) begin
      ld_q_valid <= ld_d_valid;
      ld_q_data  <= ld_d_data;
    end
  end

  a_load: assert property (@(posedge clk) disable iff (!rst_n)
    ld_q_valid |-> load_data_wb == ld_q_data)
    else stop_on_error($sformatf("ERR %0t: load_data_wb %h, expected %h",
                                 $time, load_data_wb, ld_q_data));
  a_fwd_m: assert property (@(posedge clk) disable iff (!rst_n)
    ex_mem.res_src == rv_mem_pkg::RES_M |-> result_mem == ex_mem.m_result)
    else stop_on_error($sformatf("ERR %0t: result_mem %h is not m_result", $time, result_mem));
  a_fwd_alu: assert property (@(posedge clk) disable iff (!rst_n)
    ex_mem.res_src != rv_mem_pkg::RES_M |-> result_mem == ex_mem.alu_result)
    else stop_on_error($sformatf("ERR %0t: result_mem %h is not alu_result", $time, result_mem));
  a_wb_load: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) && !$past(mem_wb_stall) |-> mem_wb.instr == $past(ex_mem.instr) &&
    mem_wb.rd == $past(ex_mem.rd) && mem_wb.res_src == $past(ex_mem.res_src) &&
    mem_wb.reg_write == $past(ex_mem.reg_write) && mem_wb.m_result == $past(ex_mem.m_result) &&
    mem_wb.alu_result == $past(ex_mem.alu_result) && mem_wb.pc_plus4 == $past(ex_mem.pc_plus4) &&
    mem_wb.funct3 == $past(ex_mem.funct3) && mem_wb.addr_lo == $past(ex_mem.alu_result[1:0]) &&
    mem_wb.jb_target == $past(ex_mem.jb_target) &&
    mem_wb.csr_rdata == $past(ex_mem.csr_rdata))
    else stop_on_error($sformatf("ERR %0t: mem_wb does not follow ex_mem", $time));
  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) && $past(mem_wb_stall) |-> mem_wb == $past(mem_wb))
    else stop_on_error($sformatf("ERR %0t: mem_wb changed under stall", $time));
  a_host_rd: assert property (@(posedge clk) disable iff (!rst_n)
    hrd_valid |-> host_rdata == hrd_data)
    else stop_on_error($sformatf("ERR %0t: host_rdata %h, expected %h",
                                 $time, host_rdata, hrd_data));

  initial begin
    rv_mem_pkg::ex_mem_t e;
    logic [31:0] r;
    logic [31:0] a2;
    rst_n = 1'b0;
    mem_wb_stall = 1'b0;
    ex_mem = '0;
    // Host request raised through reset
    host_req = 1'b1;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    host_wstrb = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // Fill every word so no load sees an unwritten location
    for (int w = 0; w < 64; w++) host_access(1'b1, 8'(w * 4), 4'hf, 2'd0);
    for (int it = 0; it < 300; it++) begin
      take_bits(12, r);
      take_bits(8, a2);
      case (r[1:0])
        2'd0: begin
          mem_op(1'b1, r[11:4], r[4:2], e);
          pipe_cycle(e, 1'b0);
          mem_op(1'b0, a2[0] ? r[11:4] : a2[7:0], a2[3:1], e);
          pipe_cycle(e, 1'b0);
        end
        2'd1: begin
          random_idle(e);
          pipe_cycle(e, 1'b0);
        end
        2'd2: host_access(r[2], r[11:4], r[7:4], a2[5:4]);
        default: begin
          mem_op(1'b0, r[11:4], r[4:2], e);
          pipe_cycle(e, 1'b0);
          repeat (int'(r[3:2]) + 1) pipe_cycle(e, 1'b1);
        end
      endcase
    end
    random_idle(e);
    pipe_cycle(e, 1'b0);
    pipe_cycle(e, 1'b0);
    if (UUT.u_asserts.fail_cnt != 0) begin
      stop_on_error("A bound protocol assertion failed during the run");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
src/rv_mem_pkg.sv
src/rv_st_fmt.sv
src/rv_ld_fmt.sv
src/rv_dmem.sv
src/rv_dmem_arb.sv
src/rv_stage_mem.sv
src/rv_mem_sub.sv
bench/rv_mem_sub_asserts.sv
bench/rv_mem_sub_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rv_mem_sub_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := run.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
